// File: source/sdram_pkg.sv
package sdram_pkg;

	// Read latency also programmed into the mode register
	localparam int CAS_LATENCY = 2;
	// Burst length of one
	localparam logic [2:0] BURST_CODE = 3'b000;

	// Timing limits in clocks with init wait and refresh period scaled for simulation
	localparam int T_INIT = 100;
	localparam int T_REFC = 200;
	localparam int T_RC = 8;
	localparam int T_RAS = 6;
	localparam int T_RP = 2;
	localparam int T_MRD = 2;
	localparam int T_RCD = 2;
	localparam int T_DPL = 2;

	typedef enum logic [2:0] {NOP, READ, WRITE, ACT, PRE, PALL, REF, MRS} sdram_cmd_e;

	// Flat word address for the user and split view for the command path
	typedef union packed {
		logic [23:0] flat;
		struct packed {
			logic [1:0] bank;
			logic [12:0] row;
			logic [8:0] column;
		} loc;
	} sdram_addr_u;

	typedef struct packed {
		logic we;
		sdram_addr_u addr;
		logic [15:0] data;
	} sdram_req_t;

	typedef struct packed {
		logic cke;
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [1:0] ba;
		logic [12:0] addr;
		logic [1:0] dqm;
	} sdram_pins_t;

	typedef struct packed {
		sdram_addr_u addr;
		logic [15:0] data;
	} sdram_resp_t;

endpackage

// File: source/sdram_req_buffer.sv
`timescale 1ns/10ps

module sdram_req_buffer (
	input logic clk,
	input logic n_reset,
	input logic req,
	input sdram_pkg::sdram_req_t req_in,
	input logic ack,
	output logic rdy,
	output logic pending,
	output sdram_pkg::sdram_req_t held
);

	// Free slot or the held one leaving on this clock
	assign rdy = ack || !pending;

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			pending <= 1'b0;
		end else if (rdy) begin
			pending <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (rdy) begin
			held <= req_in;
		end
	end

endmodule

// File: source/sdram_bank.sv
`timescale 1ns/10ps

module sdram_bank (
	input logic clk,
	input logic n_reset,
	input logic sel,
	input logic cmd_pre,
	input logic cmd_act,
	input logic cmd_write,
	input logic [12:0] row,
	output logic active,
	output logic match,
	output logic pre_ok,
	output logic act_ok,
	output logic rw_ok
);
	import sdram_pkg::*;

	logic act_hit;
	logic pre_hit;
	logic write_hit;
	logic [12:0] open_row;
	logic [7:0] rc_cnt;
	logic [7:0] ras_cnt;
	logic [7:0] rcd_cnt;
	logic [7:0] rp_cnt;
	logic [7:0] dpl_cnt;

	// Count down and hold at zero
	function automatic logic [7:0] tick(input logic [7:0] value);
		return (value == 8'd0) ? value : value - 8'd1;
	endfunction

	assign act_hit = sel && cmd_act;
	assign pre_hit = sel && cmd_pre;
	assign write_hit = sel && cmd_write;

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			active <= 1'b0;
			rc_cnt <= 8'd0;
			ras_cnt <= 8'd0;
			rcd_cnt <= 8'd0;
			rp_cnt <= 8'd0;
			dpl_cnt <= 8'd0;
		end else begin
			if (act_hit) begin
				active <= 1'b1;
			end else if (pre_hit) begin
				active <= 1'b0;
			end
			rc_cnt <= act_hit ? 8'(T_RC - 1) : tick(rc_cnt);
			ras_cnt <= act_hit ? 8'(T_RAS - 1) : tick(ras_cnt);
			rcd_cnt <= act_hit ? 8'(T_RCD - 1) : tick(rcd_cnt);
			rp_cnt <= pre_hit ? 8'(T_RP - 1) : tick(rp_cnt);
			dpl_cnt <= write_hit ? 8'(T_DPL - 1) : tick(dpl_cnt);
		end
	end

	always_ff @(posedge clk) begin
		if (act_hit) begin
			open_row <= row;
		end
	end

	assign match = active && (open_row == row);
	assign act_ok = (rc_cnt == 8'd0) && (rp_cnt == 8'd0);
	assign pre_ok = (ras_cnt == 8'd0) && (dpl_cnt == 8'd0);
	assign rw_ok = (rcd_cnt == 8'd0);

endmodule

// File: source/sdram_read_return.sv
`timescale 1ns/10ps

module sdram_read_return (
	input logic clk,
	input logic n_reset,
	input logic rd,
	input sdram_pkg::sdram_addr_u rd_addr,
	input logic [15:0] dq,
	output sdram_pkg::sdram_resp_t resp,
	output logic rdy_out
);
	import sdram_pkg::*;

	logic [CAS_LATENCY-1:0] rd_pipe;
	sdram_addr_u addr_pipe [CAS_LATENCY];

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			rd_pipe <= '0;
			rdy_out <= 1'b0;
		end else begin
			rd_pipe[0] <= rd;
			for (int i = 1; i < CAS_LATENCY; i++) begin
				rd_pipe[i] <= rd_pipe[i - 1];
			end
			rdy_out <= rd_pipe[CAS_LATENCY - 1];
		end
	end

	// Address travels with its read flag while DQ is sampled as the last stage leaves
	always_ff @(posedge clk) begin
		addr_pipe[0] <= rd_addr;
		for (int i = 1; i < CAS_LATENCY; i++) begin
			addr_pipe[i] <= addr_pipe[i - 1];
		end
		resp.addr <= addr_pipe[CAS_LATENCY - 1];
		resp.data <= dq;
	end

endmodule

// File: source/sdram_sequencer.sv
`timescale 1ns/10ps

module sdram_sequencer (
	input logic clk,
	input logic n_reset,
	input logic pending,
	input sdram_pkg::sdram_req_t held,
	output logic ack,
	output logic [3:0] bank_sel,
	output logic [3:0] bank_pre,
	output logic [3:0] bank_act,
	output logic [3:0] bank_write,
	output logic [12:0] row,
	input logic [3:0] active,
	input logic [3:0] match,
	input logic [3:0] pre_ok,
	input logic [3:0] act_ok,
	input logic [3:0] rw_ok,
	output logic rd,
	output sdram_pkg::sdram_addr_u rd_addr,
	output sdram_pkg::sdram_pins_t pins,
	inout wire [15:0] dq
);
	import sdram_pkg::*;

	typedef enum logic [2:0] {
		S_RESET, S_INIT, S_PALL, S_REF, S_REF2, S_MRS, S_EXEC, S_CLOSE
	} state_e;

	state_e state;
	state_e state_next;
	sdram_cmd_e cmd;
	logic [15:0] cnt;
	logic [15:0] cnt_load;
	logic advance;
	logic execute;
	logic mode_set;
	logic [2:0] turn_cnt;
	logic [1:0] ba;

	assign ba = held.addr.loc.bank;
	assign row = held.addr.loc.row;

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			state <= S_RESET;
			cnt <= 16'd0;
		end else if (advance) begin
			state <= state_next;
			cnt <= cnt_load;
		end else if (cnt != 16'd0) begin
			cnt <= cnt - 16'd1;
		end
	end

	always_comb begin
		state_next = state;
		cnt_load = 16'd0;
		advance = (cnt == 16'd0);
		execute = 1'b0;
		cmd = NOP;
		case (state)
		S_RESET: begin
			state_next = S_INIT;
			cnt_load = 16'(T_INIT - 1);
		end
		S_INIT: begin
			state_next = S_PALL;
			cnt_load = 16'(T_RP - 1);
			cmd = advance ? PALL : NOP;
		end
		S_PALL: begin
			state_next = S_REF;
			cnt_load = 16'(T_RC - 1);
			cmd = advance ? REF : NOP;
		end
		S_REF: begin
			// Init needs a second refresh before the mode write
			if (mode_set) begin
				state_next = S_EXEC;
				cnt_load = 16'(T_REFC - T_RC - T_RP - T_DPL - 2);
			end else begin
				state_next = S_REF2;
				cnt_load = 16'(T_RC - 1);
				cmd = advance ? REF : NOP;
			end
		end
		S_REF2: begin
			state_next = S_MRS;
			cnt_load = 16'(T_MRD - 1);
			cmd = advance ? MRS : NOP;
		end
		S_MRS: begin
			// Mode write delay comes out of the first refresh window
			state_next = S_EXEC;
			cnt_load = 16'(T_REFC - T_RC - T_MRD - T_RP - T_DPL - 2);
		end
		S_EXEC: begin
			state_next = S_CLOSE;
			execute = 1'b1;
		end
		S_CLOSE: begin
			// Wait out tRAS and write recovery on every open bank
			state_next = S_PALL;
			cnt_load = 16'(T_RP - 1);
			advance = &(pre_ok | ~active);
			cmd = advance ? PALL : NOP;
		end
		default: ;
		endcase

		if (execute && pending) begin
			if (!active[ba]) begin
				// No new row once the refresh is too near to respect tRAS
				if (act_ok[ba] && cnt >= 16'(T_RAS)) begin
					cmd = ACT;
				end
			end else if (!match[ba]) begin
				if (pre_ok[ba]) begin
					cmd = PRE;
				end
			end else if (rw_ok[ba]) begin
				if (!held.we) begin
					cmd = READ;
				end else if (turn_cnt == 3'd0) begin
					cmd = WRITE;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			mode_set <= 1'b0;
			turn_cnt <= 3'd0;
		end else begin
			if (cmd == MRS) begin
				mode_set <= 1'b1;
			end
			// Keep the bus free until read data has gone
			if (cmd == READ) begin
				turn_cnt <= 3'(CAS_LATENCY + 1);
			end else if (turn_cnt != 3'd0) begin
				turn_cnt <= turn_cnt - 3'd1;
			end
		end
	end

	assign ack = (cmd == READ) || (cmd == WRITE);
	assign rd = (cmd == READ);
	assign rd_addr = held.addr;

	always_comb begin
		bank_sel = {4{cmd == PALL}};
		bank_sel[ba] = 1'b1;
	end

	assign bank_pre = {4{(cmd == PRE) || (cmd == PALL)}};
	assign bank_act = {4{cmd == ACT}};
	assign bank_write = {4{cmd == WRITE}};

	assign dq = (cmd == WRITE) ? held.data : 16'bz;

	always_comb begin
		pins.cke = (state != S_RESET);
		pins.cs_n = (state == S_RESET);
		pins.ras_n = 1'b1;
		pins.cas_n = 1'b1;
		pins.we_n = 1'b1;
		pins.ba = ba;
		pins.addr = {4'b0000, held.addr.loc.column};
		pins.dqm = 2'b00;
		case (cmd)
		READ: begin
			pins.cas_n = 1'b0;
		end
		WRITE: begin
			pins.cas_n = 1'b0;
			pins.we_n = 1'b0;
		end
		ACT: begin
			pins.ras_n = 1'b0;
			pins.addr = row;
		end
		PRE: begin
			pins.ras_n = 1'b0;
			pins.we_n = 1'b0;
			pins.addr[10] = 1'b0;
		end
		PALL: begin
			pins.ras_n = 1'b0;
			pins.we_n = 1'b0;
			pins.addr[10] = 1'b1;
		end
		REF: begin
			pins.ras_n = 1'b0;
			pins.cas_n = 1'b0;
		end
		MRS: begin
			pins.ras_n = 1'b0;
			pins.cas_n = 1'b0;
			pins.we_n = 1'b0;
			// Programmed burst for writes with sequential order
			{pins.ba, pins.addr} = {5'b00000, 1'b0, 2'b00, 3'(CAS_LATENCY), 1'b0, BURST_CODE};
		end
		default: ;
		endcase
	end

endmodule

// File: source/sdram_top.sv
`timescale 1ns/10ps

module sdram_top (
	input logic clk,
	input logic n_reset,
	input logic req,
	input sdram_pkg::sdram_req_t req_in,
	output logic rdy,
	output sdram_pkg::sdram_pins_t pins,
	inout wire [15:0] dq,
	output sdram_pkg::sdram_resp_t resp,
	output logic rdy_out
);
	import sdram_pkg::*;

	logic ack;
	logic pending;
	sdram_req_t held;
	logic [3:0] bank_sel;
	logic [3:0] bank_pre;
	logic [3:0] bank_act;
	logic [3:0] bank_write;
	logic [12:0] row;
	logic [3:0] active;
	logic [3:0] match;
	logic [3:0] pre_ok;
	logic [3:0] act_ok;
	logic [3:0] rw_ok;
	logic rd;
	sdram_addr_u rd_addr;

	sdram_req_buffer u_buffer (
		.clk(clk),
		.n_reset(n_reset),
		.req(req),
		.req_in(req_in),
		.ack(ack),
		.rdy(rdy),
		.pending(pending),
		.held(held)
	);

	sdram_sequencer u_sequencer (
		.clk(clk),
		.n_reset(n_reset),
		.pending(pending),
		.held(held),
		.ack(ack),
		.bank_sel(bank_sel),
		.bank_pre(bank_pre),
		.bank_act(bank_act),
		.bank_write(bank_write),
		.row(row),
		.active(active),
		.match(match),
		.pre_ok(pre_ok),
		.act_ok(act_ok),
		.rw_ok(rw_ok),
		.rd(rd),
		.rd_addr(rd_addr),
		.pins(pins),
		.dq(dq)
	);

	// One tracker per bank
	for (genvar i = 0; i < 4; i++) begin : g_bank
		sdram_bank u_bank (
			.clk(clk),
			.n_reset(n_reset),
			.sel(bank_sel[i]),
			.cmd_pre(bank_pre[i]),
			.cmd_act(bank_act[i]),
			.cmd_write(bank_write[i]),
			.row(row),
			.active(active[i]),
			.match(match[i]),
			.pre_ok(pre_ok[i]),
			.act_ok(act_ok[i]),
			.rw_ok(rw_ok[i])
		);
	end

	sdram_read_return u_read_return (
		.clk(clk),
		.n_reset(n_reset),
		.rd(rd),
		.rd_addr(rd_addr),
		.dq(dq),
		.resp(resp),
		.rdy_out(rdy_out)
	);

endmodule

// File: bench/sdram_chip_model.sv
`timescale 1ns/10ps

module sdram_chip_model (
	input logic clk,
	input sdram_pkg::sdram_pins_t pins,
	inout wire [15:0] dq,
	output logic violation,
	output logic [2:0] init_step
);
	import sdram_pkg::*;

	sdram_cmd_e cmd;
	sdram_cmd_e init_order [4];
	logic [3:0] open_bank;
	logic [12:0] open_row [4];
	int act_cycle [4];
	int cycle;
	int last_ref;
	logic [15:0] mem [logic [23:0]];
	logic [CAS_LATENCY-1:0] rd_stage;
	logic [15:0] rd_data [CAS_LATENCY];
	logic [23:0] key;

	// Command decode from the control pins
	always_comb begin
		cmd = NOP;
		if (pins.cke && !pins.cs_n) begin
			case ({pins.ras_n, pins.cas_n, pins.we_n})
			3'b101: cmd = READ;
			3'b100: cmd = WRITE;
			3'b011: cmd = ACT;
			3'b010: cmd = pins.addr[10] ? PALL : PRE;
			3'b001: cmd = REF;
			3'b000: cmd = MRS;
			default: cmd = NOP;
			endcase
		end
	end

	assign key = {pins.ba, open_row[pins.ba], pins.addr[8:0]};
	assign dq = rd_stage[CAS_LATENCY-1] ? rd_data[CAS_LATENCY-1] : 16'bz;

	task automatic flag(input string what);
		$display("Chip model: %s at cycle %0d", what, cycle);
		violation = 1'b1;
	endtask

	initial begin
		violation = 1'b0;
		init_step = 3'd0;
		open_bank = 4'b0000;
		cycle = 0;
		last_ref = -1;
		rd_stage = '0;
		init_order = '{PALL, REF, REF, MRS};
	end

	always @(posedge clk) begin
		cycle++;
		rd_stage <= {rd_stage[CAS_LATENCY-2:0], 1'b0};
		for (int i = 1; i < CAS_LATENCY; i++) begin
			rd_data[i] <= rd_data[i - 1];
		end
		if (last_ref >= 0 && cycle - last_ref > T_REFC) begin
			flag("refresh interval exceeded");
		end
		// Power-up sequence must come first and in order
		if (init_step < 3'd4 && cmd != NOP) begin
			if (cmd != init_order[init_step]) begin
				flag("power-up command out of order");
			end else begin
				init_step <= init_step + 3'd1;
			end
		end
		case (cmd)
		ACT: begin
			if (open_bank[pins.ba]) begin
				flag("ACT to an open bank");
			end
			open_bank[pins.ba] = 1'b1;
			open_row[pins.ba] = pins.addr;
			act_cycle[pins.ba] = cycle;
		end
		READ, WRITE: begin
			if (!open_bank[pins.ba]) begin
				flag("READ or WRITE to a closed bank");
			end
			if (cycle - act_cycle[pins.ba] < T_RCD) begin
				flag("tRCD violated");
			end
			if (cmd == WRITE) begin
				mem[key] = dq;
			end else begin
				rd_stage[0] <= 1'b1;
				rd_data[0] <= mem.exists(key) ? mem[key] : 16'h0000;
			end
		end
		PRE: begin
			if (open_bank[pins.ba] && cycle - act_cycle[pins.ba] < T_RAS) begin
				flag("tRAS violated on PRE");
			end
			open_bank[pins.ba] = 1'b0;
		end
		PALL: begin
			for (int b = 0; b < 4; b++) begin
				if (open_bank[b] && cycle - act_cycle[b] < T_RAS) begin
					flag("tRAS violated on PALL");
				end
			end
			open_bank = 4'b0000;
		end
		REF: begin
			if (|open_bank) begin
				flag("REF while a bank is open");
			end
			last_ref = cycle;
		end
		MRS: begin
			if (pins.addr[6:4] != 3'(CAS_LATENCY) || pins.addr[2:0] != BURST_CODE) begin
				flag("mode register value wrong");
			end
		end
		default: ;
		endcase
	end

endmodule

// File: bench/sdram_tb.sv
`timescale 1ns/10ps

module sdram_tb;
	import sdram_pkg::*;

	localparam int NUM_REQ = 300;
	localparam int CLK_NS = 100;

	logic clk;
	logic n_reset;
	logic req;
	sdram_req_t req_in;
	logic rdy;
	sdram_pins_t pins;
	wire [15:0] dq;
	sdram_resp_t resp;
	logic rdy_out;
	logic violation;
	logic [2:0] init_step;
	logic [31:0] lfsr;
	logic [15:0] ref_mem [logic [23:0]];
	sdram_resp_t expect_q [$];
	string test_name;
	int cycles_since_reset;
	sdram_resp_t head;

	sdram_top uut (
		.clk(clk),
		.n_reset(n_reset),
		.req(req),
		.req_in(req_in),
		.rdy(rdy),
		.pins(pins),
		.dq(dq),
		.resp(resp),
		.rdy_out(rdy_out)
	);

	sdram_chip_model u_chip (
		.clk(clk),
		.pins(pins),
		.dq(dq),
		.violation(violation),
		.init_step(init_step)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string field, input logic [23:0] exp,
			input logic [23:0] act);
		$display("ERR %s %s expected %h actual %h", test_name, field, exp, act);
		stop_with_failure("Value mismatch");
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = 16'h0000;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	initial begin
		#((T_INIT + NUM_REQ * T_REFC) * CLK_NS);
		stop_with_failure("Timeout, the run did not finish in time");
	end

	// Clocks since reset release, counted where reset is stable
	always @(posedge clk) begin
		if (!n_reset) begin
			cycles_since_reset = 0;
		end else begin
			cycles_since_reset++;
		end
	end

	always @(negedge clk) begin
		if (cycles_since_reset < T_INIT) begin
			assert (!pins.cke || pins.cs_n || (pins.ras_n && pins.cas_n && pins.we_n))
			else stop_with_failure("Command issued during the power-up wait");
			assert (!rdy_out) else stop_with_failure("rdy_out raised during the power-up wait");
		end
		assert (pins.dqm == 2'b00) else value_error("dqm", 24'd0, 24'(pins.dqm));
		assert (!violation) else stop_with_failure("Chip model saw a protocol violation");
		if (rdy_out) begin
			assert (expect_q.size() > 0) else stop_with_failure("Response with no read pending");
			head = expect_q.pop_front();
			assert (resp.addr.flat == head.addr.flat)
			else value_error("addr", head.addr.flat, resp.addr.flat);
			assert (resp.data == head.data)
			else value_error("data", 24'(head.data), 24'(resp.data));
		end
	end

	task automatic send_request(input logic we, input logic [23:0] addr, input logic [15:0] data);
		sdram_resp_t exp;
		@(negedge clk);
		req = 1'b1;
		req_in.we = we;
		req_in.addr.flat = addr;
		req_in.data = data;
		while (!rdy) @(negedge clk);
		if (we) begin
			ref_mem[addr] = data;
		end else begin
			exp.addr.flat = addr;
			exp.data = ref_mem[addr];
			expect_q.push_back(exp);
		end
		@(posedge clk);
	endtask

	task automatic wait_for_responses();
		int count;
		count = 0;
		@(negedge clk);
		req = 1'b0;
		while (expect_q.size() != 0 && count < 1000) begin
			@(negedge clk);
			count++;
		end
		assert (expect_q.size() == 0) else stop_with_failure("Expected read responses never came");
	endtask

	initial begin
		logic we;
		logic [1:0] bank;
		logic [12:0] row;
		logic [8:0] column;
		logic [15:0] data;
		logic [23:0] addr;
		n_reset = 1'b0;
		req = 1'b0;
		req_in = '0;
		lfsr = 32'hf6e0_b9dc;
		test_name = "reset";
		cycles_since_reset = 0;
		repeat (3) @(negedge clk);
		n_reset = 1'b1;

		test_name = "write_read";
		addr = {2'd1, 13'h0123, 9'h045};
		send_request(1'b1, addr, 16'h5a3c);
		send_request(1'b0, addr, 16'h0000);
		wait_for_responses();

		test_name = "random";
		for (int n = 0; n < NUM_REQ; n++) begin
			we = 1'(take_bits(1));
			bank = 2'(take_bits(2));
			// A few rows per bank for hits and misses
			row = 13'(take_bits(2)) * 13'd1031;
			column = 9'(take_bits(3));
			data = take_bits(16);
			addr = {bank, row, column};
			if (!we && !ref_mem.exists(addr)) begin
				we = 1'b1;
			end
			send_request(we, addr, data);
		end
		wait_for_responses();

		test_name = "init";
		assert (init_step == 3'd4) else stop_with_failure("Power-up sequence not completed");
		if (!violation && expect_q.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_with_failure("Errors remained at the end of the run");
		end
	end

endmodule

// File: project.f
source/sdram_pkg.sv
source/sdram_req_buffer.sv
source/sdram_bank.sv
source/sdram_read_return.sv
source/sdram_sequencer.sv
source/sdram_top.sv
bench/sdram_chip_model.sv
bench/sdram_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP ?= sdram_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
